// File: src/core_mem_pkg.sv
`default_nettype none

package core_mem_pkg;

    // ****************************************
    // widths
    // ****************************************
    localparam int XLEN   = 64;
    localparam int ADDR_W = 32;
    localparam int INST_W = 32;
    localparam int STRB_W = XLEN / 8;

    // ****************************************
    // basic types
    // ****************************************
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [XLEN-1:0]   xdata_t;
    typedef logic [INST_W-1:0] inst_t;
    typedef logic [STRB_W-1:0] strb_t;

    // access width of a load or store
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_H = 2'd1;
    localparam mem_size_t SIZE_W = 2'd2;
    localparam mem_size_t SIZE_D = 2'd3;

    // ****************************************
    // arbiter FSM
    // ****************************************
    // one owner at a time, data side wins ties
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_IF   = 2'd1,
        ARB_LS   = 2'd2
    } arb_state_e;

endpackage

`default_nettype wire

// File: src/inst_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module inst_fetch (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // fetch request
    input  logic                 fetch_req_valid_i,
    output logic                 fetch_req_ready_o,
    input  core_mem_pkg::addr_t  fetch_pc_i,
    // fetch response
    output logic                 fetch_rsp_valid_o,
    input  logic                 fetch_rsp_ready_i,
    output core_mem_pkg::inst_t  fetch_rsp_inst_o,
    output core_mem_pkg::addr_t  fetch_rsp_pc_o,
    input  logic                 jmp_flush_i,
    // arbiter side
    output logic                 if_req_valid_o,
    output core_mem_pkg::addr_t  if_req_addr_o,
    input  logic                 if_gnt_i,
    input  logic                 if_rsp_valid_i,
    input  core_mem_pkg::xdata_t if_rsp_rdata_i
);
    import core_mem_pkg::*;

    logic  ready_q;
    logic  req_pend_q;
    logic  in_flight_q;
    logic  dropped_q;
    logic  rsp_valid_q;
    addr_t pc_q;
    inst_t inst_q;

    logic  req_fire;
    logic  rsp_keep;
    logic  in_flight_d;
    logic  rsp_valid_d;
    inst_t inst_sel;

    assign req_fire    = fetch_req_valid_i & ready_q;
    // a flush on the way back discards the word
    assign rsp_keep    = if_rsp_valid_i & in_flight_q & ~dropped_q & ~jmp_flush_i;
    assign in_flight_d = req_fire | (in_flight_q & ~if_rsp_valid_i);
    assign rsp_valid_d = rsp_keep | (rsp_valid_q & ~fetch_rsp_ready_i & ~jmp_flush_i);

    // bit 2 picks the half of the double word
    assign inst_sel = pc_q[2] ? if_rsp_rdata_i[XLEN-1:INST_W] : if_rsp_rdata_i[INST_W-1:0];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q     <= 1'b0;
            req_pend_q  <= 1'b0;
            in_flight_q <= 1'b0;
            dropped_q   <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            ready_q     <= ~in_flight_d & ~rsp_valid_d;
            in_flight_q <= in_flight_d;
            rsp_valid_q <= rsp_valid_d;

            if (req_fire) begin
                req_pend_q <= 1'b1;
            end else if (if_gnt_i) begin
                req_pend_q <= 1'b0;
            end

            // dropped lives until the memory answer comes back
            if (if_rsp_valid_i) begin
                dropped_q <= 1'b0;
            end else if (jmp_flush_i && in_flight_q) begin
                dropped_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            pc_q <= fetch_pc_i;
        end
        if (rsp_keep) begin
            inst_q <= inst_sel;
        end
    end

    assign fetch_req_ready_o = ready_q;
    assign fetch_rsp_valid_o = rsp_valid_q;
    assign fetch_rsp_inst_o  = inst_q;
    assign fetch_rsp_pc_o    = pc_q;

    assign if_req_valid_o = req_pend_q;
    assign if_req_addr_o  = {pc_q[ADDR_W-1:3], 3'b000};

endmodule

`default_nettype wire

// File: src/load_store.sv
`default_nettype none
`timescale 1ns/1ps

module load_store (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // access request
    input  logic                      lsu_req_valid_i,
    output logic                      lsu_req_ready_o,
    input  core_mem_pkg::addr_t       lsu_addr_i,
    input  logic                      lsu_we_i,
    input  core_mem_pkg::xdata_t      lsu_wdata_i,
    input  core_mem_pkg::mem_size_t   lsu_size_i,
    input  logic                      lsu_unsigned_i,
    // access response
    output logic                      lsu_rsp_valid_o,
    input  logic                      lsu_rsp_ready_i,
    output core_mem_pkg::xdata_t      lsu_rsp_rdata_o,
    output logic                      lsu_rsp_err_o,
    // arbiter side
    output logic                      ls_req_valid_o,
    output logic                      ls_req_we_o,
    output core_mem_pkg::addr_t       ls_req_addr_o,
    output core_mem_pkg::xdata_t      ls_req_wdata_o,
    output core_mem_pkg::strb_t       ls_req_strb_o,
    input  logic                      ls_gnt_i,
    input  logic                      ls_rsp_valid_i,
    input  core_mem_pkg::xdata_t      ls_rsp_rdata_i
);
    import core_mem_pkg::*;

    logic      ready_q;
    logic      req_pend_q;
    logic      busy_q;
    logic      rsp_valid_q;
    logic      err_q;
    xdata_t    rdata_q;
    addr_t     addr_q;
    logic      we_q;
    xdata_t    wdata_q;
    mem_size_t size_q;
    logic      unsigned_q;

    logic      req_fire;
    logic      misalign;
    logic      busy_d;
    logic      rsp_valid_d;
    xdata_t    load_shift;
    xdata_t    load_ext;
    logic      sign_bit;
    strb_t     strb;

    assign req_fire = lsu_req_valid_i & ready_q;

    // natural alignment for the access width
    always_comb begin
        case (lsu_size_i)
            SIZE_B:  misalign = 1'b0;
            SIZE_H:  misalign = lsu_addr_i[0];
            SIZE_W:  misalign = |lsu_addr_i[1:0];
            default: misalign = |lsu_addr_i[2:0];
        endcase
    end

    assign busy_d      = (req_fire & ~misalign) | (busy_q & ~ls_rsp_valid_i);
    assign rsp_valid_d = (req_fire & misalign) | (busy_q & ls_rsp_valid_i)
                       | (rsp_valid_q & ~lsu_rsp_ready_i);

    // ****************************************
    // store lanes
    // ****************************************
    always_comb begin
        case (size_q)
            SIZE_B:  strb = 8'b0000_0001 << addr_q[2:0];
            SIZE_H:  strb = 8'b0000_0011 << addr_q[2:0];
            SIZE_W:  strb = 8'b0000_1111 << addr_q[2:0];
            default: strb = 8'b1111_1111;
        endcase
    end

    // ****************************************
    // load extension
    // ****************************************
    always_comb begin
        load_shift = ls_rsp_rdata_i >> {addr_q[2:0], 3'b000};
        case (size_q)
            SIZE_B: begin
                sign_bit = ~unsigned_q & load_shift[7];
                load_ext = {{(XLEN-8){sign_bit}}, load_shift[7:0]};
            end
            SIZE_H: begin
                sign_bit = ~unsigned_q & load_shift[15];
                load_ext = {{(XLEN-16){sign_bit}}, load_shift[15:0]};
            end
            SIZE_W: begin
                sign_bit = ~unsigned_q & load_shift[31];
                load_ext = {{(XLEN-32){sign_bit}}, load_shift[31:0]};
            end
            default: begin
                sign_bit = 1'b0;
                load_ext = load_shift;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q     <= 1'b0;
            req_pend_q  <= 1'b0;
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            ready_q     <= ~busy_d & ~rsp_valid_d;
            busy_q      <= busy_d;
            rsp_valid_q <= rsp_valid_d;
            if (req_fire && !misalign) begin
                req_pend_q <= 1'b1;
            end else if (ls_gnt_i) begin
                req_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            addr_q     <= lsu_addr_i;
            we_q       <= lsu_we_i;
            wdata_q    <= lsu_wdata_i;
            size_q     <= lsu_size_i;
            unsigned_q <= lsu_unsigned_i;
            err_q      <= misalign;
            rdata_q    <= '0;
        end else if (busy_q && ls_rsp_valid_i) begin
            // stores answer with zero data
            rdata_q <= we_q ? '0 : load_ext;
        end
    end

    assign lsu_req_ready_o = ready_q;
    assign lsu_rsp_valid_o = rsp_valid_q;
    assign lsu_rsp_rdata_o = rdata_q;
    assign lsu_rsp_err_o   = err_q;

    assign ls_req_valid_o = req_pend_q;
    assign ls_req_we_o    = we_q;
    assign ls_req_addr_o  = {addr_q[ADDR_W-1:3], 3'b000};
    assign ls_req_wdata_o = wdata_q << {addr_q[2:0], 3'b000};
    assign ls_req_strb_o  = strb;

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    // fetch master
    input  logic                 if_req_valid_i,
    input  core_mem_pkg::addr_t  if_req_addr_i,
    output logic                 if_gnt_o,
    output logic                 if_rsp_valid_o,
    output core_mem_pkg::xdata_t if_rsp_rdata_o,
    // data master
    input  logic                 ls_req_valid_i,
    input  logic                 ls_req_we_i,
    input  core_mem_pkg::addr_t  ls_req_addr_i,
    input  core_mem_pkg::xdata_t ls_req_wdata_i,
    input  core_mem_pkg::strb_t  ls_req_strb_i,
    output logic                 ls_gnt_o,
    output logic                 ls_rsp_valid_o,
    output core_mem_pkg::xdata_t ls_rsp_rdata_o,
    // memory bus
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,
    output logic                 mem_req_we_o,
    output core_mem_pkg::addr_t  mem_req_addr_o,
    output core_mem_pkg::xdata_t mem_req_wdata_o,
    output core_mem_pkg::strb_t  mem_req_strb_o,
    input  logic                 mem_rsp_valid_i,
    input  core_mem_pkg::xdata_t mem_rsp_rdata_i
);
    import core_mem_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    logic       mem_valid_q;
    logic       we_q;
    addr_t      addr_q;
    xdata_t     wdata_q;
    strb_t      strb_q;

    logic       arb_idle;

    // ****************************************
    // grant
    // ****************************************
    assign arb_idle = (state_q == ARB_IDLE);
    assign ls_gnt_o = arb_idle & ls_req_valid_i;
    assign if_gnt_o = arb_idle & if_req_valid_i & ~ls_req_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (ls_req_valid_i) begin
                    state_d = ARB_LS;
                end else if (if_req_valid_i) begin
                    state_d = ARB_IF;
                end
            end
            ARB_IF, ARB_LS: begin
                // single outstanding, back to idle on the answer
                if (mem_rsp_valid_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ARB_IDLE;
            mem_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ls_gnt_o || if_gnt_o) begin
                mem_valid_q <= 1'b1;
            end else if (mem_req_ready_i) begin
                mem_valid_q <= 1'b0;
            end
        end
    end

    // ****************************************
    // request capture
    // ****************************************
    always_ff @(posedge clk_i) begin
        if (ls_gnt_o) begin
            we_q    <= ls_req_we_i;
            addr_q  <= ls_req_addr_i;
            wdata_q <= ls_req_wdata_i;
            strb_q  <= ls_req_strb_i;
        end else if (if_gnt_o) begin
            // fetch is a plain read
            we_q    <= 1'b0;
            addr_q  <= if_req_addr_i;
            wdata_q <= '0;
            strb_q  <= '0;
        end
    end

    assign mem_req_valid_o = mem_valid_q;
    assign mem_req_we_o    = we_q;
    assign mem_req_addr_o  = addr_q;
    assign mem_req_wdata_o = wdata_q;
    assign mem_req_strb_o  = strb_q;

    // response goes to whoever owns the bus
    assign if_rsp_valid_o = (state_q == ARB_IF) & mem_rsp_valid_i;
    assign ls_rsp_valid_o = (state_q == ARB_LS) & mem_rsp_valid_i;
    assign if_rsp_rdata_o = mem_rsp_rdata_i;
    assign ls_rsp_rdata_o = mem_rsp_rdata_i;

endmodule

`default_nettype wire

// File: src/core_mem_top.sv
`default_nettype none
`timescale 1ns/1ps

module core_mem_top (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // fetch port
    input  logic                    fetch_req_valid_i,
    output logic                    fetch_req_ready_o,
    input  core_mem_pkg::addr_t     fetch_pc_i,
    output logic                    fetch_rsp_valid_o,
    input  logic                    fetch_rsp_ready_i,
    output core_mem_pkg::inst_t     fetch_rsp_inst_o,
    output core_mem_pkg::addr_t     fetch_rsp_pc_o,
    input  logic                    jmp_flush_i,
    // load/store port
    input  logic                    lsu_req_valid_i,
    output logic                    lsu_req_ready_o,
    input  core_mem_pkg::addr_t     lsu_addr_i,
    input  logic                    lsu_we_i,
    input  core_mem_pkg::xdata_t    lsu_wdata_i,
    input  core_mem_pkg::mem_size_t lsu_size_i,
    input  logic                    lsu_unsigned_i,
    output logic                    lsu_rsp_valid_o,
    input  logic                    lsu_rsp_ready_i,
    output core_mem_pkg::xdata_t    lsu_rsp_rdata_o,
    output logic                    lsu_rsp_err_o,
    // memory bus
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output logic                    mem_req_we_o,
    output core_mem_pkg::addr_t     mem_req_addr_o,
    output core_mem_pkg::xdata_t    mem_req_wdata_o,
    output core_mem_pkg::strb_t     mem_req_strb_o,
    input  logic                    mem_rsp_valid_i,
    input  core_mem_pkg::xdata_t    mem_rsp_rdata_i
);
    import core_mem_pkg::*;

    // fetch to arbiter
    logic   if_req_valid;
    addr_t  if_req_addr;
    logic   if_gnt;
    logic   if_rsp_valid;
    xdata_t if_rsp_rdata;

    // load/store to arbiter
    logic   ls_req_valid;
    logic   ls_req_we;
    addr_t  ls_req_addr;
    xdata_t ls_req_wdata;
    strb_t  ls_req_strb;
    logic   ls_gnt;
    logic   ls_rsp_valid;
    xdata_t ls_rsp_rdata;

    inst_fetch u_fetch (
        .clk_i             ( clk_i             ),
        .arst_n_i          ( arst_n_i          ),
        .fetch_req_valid_i ( fetch_req_valid_i ),
        .fetch_req_ready_o ( fetch_req_ready_o ),
        .fetch_pc_i        ( fetch_pc_i        ),
        .fetch_rsp_valid_o ( fetch_rsp_valid_o ),
        .fetch_rsp_ready_i ( fetch_rsp_ready_i ),
        .fetch_rsp_inst_o  ( fetch_rsp_inst_o  ),
        .fetch_rsp_pc_o    ( fetch_rsp_pc_o    ),
        .jmp_flush_i       ( jmp_flush_i       ),
        .if_req_valid_o    ( if_req_valid      ),
        .if_req_addr_o     ( if_req_addr       ),
        .if_gnt_i          ( if_gnt            ),
        .if_rsp_valid_i    ( if_rsp_valid      ),
        .if_rsp_rdata_i    ( if_rsp_rdata      )
    );

    load_store u_lsu (
        .clk_i           ( clk_i           ),
        .arst_n_i        ( arst_n_i        ),
        .lsu_req_valid_i ( lsu_req_valid_i ),
        .lsu_req_ready_o ( lsu_req_ready_o ),
        .lsu_addr_i      ( lsu_addr_i      ),
        .lsu_we_i        ( lsu_we_i        ),
        .lsu_wdata_i     ( lsu_wdata_i     ),
        .lsu_size_i      ( lsu_size_i      ),
        .lsu_unsigned_i  ( lsu_unsigned_i  ),
        .lsu_rsp_valid_o ( lsu_rsp_valid_o ),
        .lsu_rsp_ready_i ( lsu_rsp_ready_i ),
        .lsu_rsp_rdata_o ( lsu_rsp_rdata_o ),
        .lsu_rsp_err_o   ( lsu_rsp_err_o   ),
        .ls_req_valid_o  ( ls_req_valid    ),
        .ls_req_we_o     ( ls_req_we       ),
        .ls_req_addr_o   ( ls_req_addr     ),
        .ls_req_wdata_o  ( ls_req_wdata    ),
        .ls_req_strb_o   ( ls_req_strb     ),
        .ls_gnt_i        ( ls_gnt          ),
        .ls_rsp_valid_i  ( ls_rsp_valid    ),
        .ls_rsp_rdata_i  ( ls_rsp_rdata    )
    );

    mem_arbiter u_arb (
        .clk_i           ( clk_i           ),
        .arst_n_i        ( arst_n_i        ),
        .if_req_valid_i  ( if_req_valid    ),
        .if_req_addr_i   ( if_req_addr     ),
        .if_gnt_o        ( if_gnt          ),
        .if_rsp_valid_o  ( if_rsp_valid    ),
        .if_rsp_rdata_o  ( if_rsp_rdata    ),
        .ls_req_valid_i  ( ls_req_valid    ),
        .ls_req_we_i     ( ls_req_we       ),
        .ls_req_addr_i   ( ls_req_addr     ),
        .ls_req_wdata_i  ( ls_req_wdata    ),
        .ls_req_strb_i   ( ls_req_strb     ),
        .ls_gnt_o        ( ls_gnt          ),
        .ls_rsp_valid_o  ( ls_rsp_valid    ),
        .ls_rsp_rdata_o  ( ls_rsp_rdata    ),
        .mem_req_valid_o ( mem_req_valid_o ),
        .mem_req_ready_i ( mem_req_ready_i ),
        .mem_req_we_o    ( mem_req_we_o    ),
        .mem_req_addr_o  ( mem_req_addr_o  ),
        .mem_req_wdata_o ( mem_req_wdata_o ),
        .mem_req_strb_o  ( mem_req_strb_o  ),
        .mem_rsp_valid_i ( mem_rsp_valid_i ),
        .mem_rsp_rdata_i ( mem_rsp_rdata_i )
    );

endmodule

`default_nettype wire

// File: tb/mem_model.sv
`default_nettype none
`timescale 1ns/1ps

module mem_model (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  logic                 req_we_i,
    input  core_mem_pkg::addr_t  req_addr_i,
    input  core_mem_pkg::xdata_t req_wdata_i,
    input  core_mem_pkg::strb_t  req_strb_i,
    output logic                 rsp_valid_o,
    output core_mem_pkg::xdata_t rsp_rdata_o
);
    import core_mem_pkg::*;

    xdata_t      mem [256];
    xdata_t      rd_q;
    logic        busy_q;
    logic [1:0]  cnt_q;
    logic [31:0] rnd;
    integer      seed;

    // each word depends on its full index
    function automatic xdata_t word_pattern(input int idx);
        return {32'h8bad_f00d ^ (idx * 32'h0100_0193), 32'h1357_9bdf + idx * 32'h9e37_79b9};
    endfunction

    initial begin
        seed = 32'h42d410dc;
        for (int i = 0; i < 256; i++) begin
            mem[i] = word_pattern(i);
        end
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_ready_o <= 1'b0;
            rsp_valid_o <= 1'b0;
            rsp_rdata_o <= '0;
            busy_q      <= 1'b0;
            cnt_q       <= 2'd0;
        end else begin
            rnd = $random(seed);
            rsp_valid_o <= 1'b0;
            if (req_valid_i && req_ready_o) begin
                req_ready_o <= 1'b0;
                busy_q      <= 1'b1;
                cnt_q       <= rnd[2:1];
                rd_q        <= req_we_i ? '0 : mem[req_addr_i[10:3]];
                if (req_we_i) begin
                    for (int b = 0; b < 8; b++) begin
                        if (req_strb_i[b]) begin
                            mem[req_addr_i[10:3]][b*8 +: 8] <= req_wdata_i[b*8 +: 8];
                        end
                    end
                end
            end else if (busy_q) begin
                if (cnt_q == 2'd0) begin
                    rsp_valid_o <= 1'b1;
                    rsp_rdata_o <= rd_q;
                    busy_q      <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 2'd1;
                end
            end else begin
                req_ready_o <= rnd[0];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_core_mem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_core_mem;
    import core_mem_pkg::*;

    localparam int TMO = 200;

    logic      clk;
    logic      arst_n;
    logic      fetch_req_valid;
    logic      fetch_req_ready;
    addr_t     fetch_pc;
    logic      fetch_rsp_valid;
    logic      fetch_rsp_ready;
    inst_t     fetch_rsp_inst;
    addr_t     fetch_rsp_pc;
    logic      jmp_flush;
    logic      lsu_req_valid;
    logic      lsu_req_ready;
    addr_t     lsu_addr;
    logic      lsu_we;
    xdata_t    lsu_wdata;
    mem_size_t lsu_size;
    logic      lsu_unsigned;
    logic      lsu_rsp_valid;
    logic      lsu_rsp_ready;
    xdata_t    lsu_rsp_rdata;
    logic      lsu_rsp_err;
    logic      mem_req_valid;
    logic      mem_req_ready;
    logic      mem_req_we;
    addr_t     mem_req_addr;
    xdata_t    mem_req_wdata;
    strb_t     mem_req_strb;
    logic      mem_rsp_valid;
    xdata_t    mem_rsp_rdata;

    xdata_t    shadow [256];
    int        errors;
    int        timeouts;

    core_mem_top u_dut (
        .clk_i (clk), .arst_n_i (arst_n),
        .fetch_req_valid_i (fetch_req_valid), .fetch_req_ready_o (fetch_req_ready),
        .fetch_pc_i (fetch_pc), .fetch_rsp_valid_o (fetch_rsp_valid),
        .fetch_rsp_ready_i (fetch_rsp_ready), .fetch_rsp_inst_o (fetch_rsp_inst),
        .fetch_rsp_pc_o (fetch_rsp_pc), .jmp_flush_i (jmp_flush),
        .lsu_req_valid_i (lsu_req_valid), .lsu_req_ready_o (lsu_req_ready),
        .lsu_addr_i (lsu_addr), .lsu_we_i (lsu_we), .lsu_wdata_i (lsu_wdata),
        .lsu_size_i (lsu_size), .lsu_unsigned_i (lsu_unsigned),
        .lsu_rsp_valid_o (lsu_rsp_valid), .lsu_rsp_ready_i (lsu_rsp_ready),
        .lsu_rsp_rdata_o (lsu_rsp_rdata), .lsu_rsp_err_o (lsu_rsp_err),
        .mem_req_valid_o (mem_req_valid), .mem_req_ready_i (mem_req_ready),
        .mem_req_we_o (mem_req_we), .mem_req_addr_o (mem_req_addr),
        .mem_req_wdata_o (mem_req_wdata), .mem_req_strb_o (mem_req_strb),
        .mem_rsp_valid_i (mem_rsp_valid), .mem_rsp_rdata_i (mem_rsp_rdata)
    );

    mem_model u_mem (
        .clk_i (clk), .arst_n_i (arst_n),
        .req_valid_i (mem_req_valid), .req_ready_o (mem_req_ready),
        .req_we_i (mem_req_we), .req_addr_i (mem_req_addr),
        .req_wdata_i (mem_req_wdata), .req_strb_i (mem_req_strb),
        .rsp_valid_o (mem_rsp_valid), .rsp_rdata_o (mem_rsp_rdata)
    );

    always #20 clk = ~clk;

    // ****************************************
    // reference model
    // ****************************************
    function automatic xdata_t word_pattern(input int idx);
        return {32'h8bad_f00d ^ (idx * 32'h0100_0193), 32'h1357_9bdf + idx * 32'h9e37_79b9};
    endfunction

    function automatic xdata_t expect_load(input addr_t addr, input mem_size_t sz,
                                           input logic uns);
        xdata_t s;
        s = shadow[addr[10:3]] >> (int'(addr[2:0]) * 8);
        case (sz)
            SIZE_B:  return uns ? {56'd0, s[7:0]} : {{56{s[7]}}, s[7:0]};
            SIZE_H:  return uns ? {48'd0, s[15:0]} : {{48{s[15]}}, s[15:0]};
            SIZE_W:  return uns ? {32'd0, s[31:0]} : {{32{s[31]}}, s[31:0]};
            default: return s;
        endcase
    endfunction

    task automatic shadow_store(input addr_t addr, input mem_size_t sz, input xdata_t data);
        int off;
        off = int'(addr[2:0]);
        for (int i = 0; i < (1 << sz); i++) begin
            shadow[addr[10:3]][(off + i)*8 +: 8] = data[i*8 +: 8];
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        timeouts++;
    endtask

    // ****************************************
    // bus drivers
    // ****************************************
    task automatic lsu_access(input logic we, input addr_t addr, input mem_size_t sz,
                              input logic uns, input xdata_t wdata, input int hold,
                              output xdata_t rdata, output logic err);
        int t;
        rdata = '0;
        err   = 1'b0;
        lsu_req_valid = 1'b1;
        lsu_we        = we;
        lsu_addr      = addr;
        lsu_size      = sz;
        lsu_unsigned  = uns;
        lsu_wdata     = wdata;
        t = 0;
        while (!lsu_req_ready && t < TMO) begin
            next_cycle();
            t++;
        end
        if (t >= TMO) begin
            lsu_req_valid = 1'b0;
            report_timeout("lsu request ready");
            return;
        end
        next_cycle();
        lsu_req_valid = 1'b0;
        t = 0;
        while (!lsu_rsp_valid && t < TMO) begin
            next_cycle();
            t++;
        end
        if (t >= TMO) begin
            report_timeout("lsu response");
            return;
        end
        rdata = lsu_rsp_rdata;
        err   = lsu_rsp_err;
        // response must hold while ready is low
        for (int h = 0; h < hold; h++) begin
            next_cycle();
            assert (lsu_rsp_valid && lsu_rsp_rdata == rdata && lsu_rsp_err == err) else begin
                $display("Fail at %0t: lsu response changed under back-pressure", $time);
                errors++;
            end
        end
        lsu_rsp_ready = 1'b1;
        next_cycle();
        lsu_rsp_ready = 1'b0;
    endtask

    task automatic check_load(input addr_t addr, input mem_size_t sz, input logic uns);
        xdata_t got;
        xdata_t exp;
        logic   err;
        exp = expect_load(addr, sz, uns);
        lsu_access(1'b0, addr, sz, uns, '0, 0, got, err);
        assert (got == exp && !err) else begin
            $display("Fail at %0t: load %h size %0d uns %0b got %h err %0b expected %h",
                     $time, addr, sz, uns, got, err, exp);
            errors++;
        end
    endtask

    task automatic check_store(input addr_t addr, input mem_size_t sz, input xdata_t data);
        xdata_t got;
        logic   err;
        lsu_access(1'b1, addr, sz, 1'b0, data, 0, got, err);
        shadow_store(addr, sz, data);
        assert (got == '0 && !err) else begin
            $display("Fail at %0t: store %h got %h err %0b", $time, addr, got, err);
            errors++;
        end
    endtask

    task automatic check_fetch(input addr_t pc);
        int     t;
        inst_t  exp;
        exp = pc[2] ? shadow[pc[10:3]][63:32] : shadow[pc[10:3]][31:0];
        fetch_req_valid = 1'b1;
        fetch_pc        = pc;
        t = 0;
        while (!fetch_req_ready && t < TMO) begin
            next_cycle();
            t++;
        end
        if (t >= TMO) begin
            fetch_req_valid = 1'b0;
            report_timeout("fetch request ready");
            return;
        end
        next_cycle();
        fetch_req_valid = 1'b0;
        t = 0;
        while (!fetch_rsp_valid && t < TMO) begin
            next_cycle();
            t++;
        end
        if (t >= TMO) begin
            report_timeout("fetch response");
            return;
        end
        assert (fetch_rsp_inst == exp && fetch_rsp_pc == pc) else begin
            $display("Fail at %0t: fetch %h got inst %h pc %h expected %h",
                     $time, pc, fetch_rsp_inst, fetch_rsp_pc, exp);
            errors++;
        end
        fetch_rsp_ready = 1'b1;
        next_cycle();
        fetch_rsp_ready = 1'b0;
    endtask

    // ****************************************
    // tests
    // ****************************************
    task automatic test_fetch_halves();
        check_fetch(32'h0000_0040);
        check_fetch(32'h0000_0044);
        check_fetch(32'h0000_0398);
        check_fetch(32'h0000_039c);
    endtask

    task automatic test_load_sizes();
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                check_load(32'h100 + sz*8 + off, mem_size_t'(sz), 1'b0);
                check_load(32'h100 + sz*8 + off, mem_size_t'(sz), 1'b1);
            end
        end
    endtask

    task automatic test_store_merge();
        for (int sz = 0; sz < 4; sz++) begin
            check_store(32'h200 + sz*8 + ((sz == 3) ? 0 : 4), mem_size_t'(sz),
                        64'hf1e2_d3c4_b5a6_9788 + 64'(sz));
            check_load(32'h200 + sz*8, SIZE_D, 1'b0);
        end
    endtask

    task automatic test_concurrent();
        fork
            check_fetch(32'h0000_0084);
            check_load(32'h0000_00c2, SIZE_H, 1'b0);
        join
        // store hits the lower half, fetch reads the upper half
        fork
            check_fetch(32'h0000_008c);
            check_store(32'h0000_0088, SIZE_W, 64'h0bad_cafe);
        join
    endtask

    task automatic test_flush();
        int t;
        fetch_req_valid = 1'b1;
        fetch_pc        = 32'h0000_0150;
        t = 0;
        while (!fetch_req_ready && t < TMO) begin
            next_cycle();
            t++;
        end
        if (t >= TMO) begin
            fetch_req_valid = 1'b0;
            report_timeout("fetch ready before flush");
            return;
        end
        next_cycle();
        fetch_req_valid = 1'b0;
        jmp_flush       = 1'b1;
        next_cycle();
        jmp_flush = 1'b0;
        t = 0;
        while (!fetch_req_ready && t < TMO) begin
            assert (!fetch_rsp_valid) else begin
                $display("Fail at %0t: flushed fetch produced a response", $time);
                errors++;
            end
            next_cycle();
            t++;
        end
        if (t >= TMO) begin
            report_timeout("fetch port free after flush");
            return;
        end
        check_fetch(32'h0000_0164);
    endtask

    task automatic test_misaligned();
        xdata_t got;
        logic   err;
        lsu_access(1'b0, 32'h0000_0301, SIZE_H, 1'b0, '0, 0, got, err);
        assert (err) else begin
            $display("Fail at %0t: misaligned load gave no error", $time);
            errors++;
        end
        lsu_access(1'b1, 32'h0000_0302, SIZE_W, 1'b0, 64'hdead_beef, 5, got, err);
        assert (err) else begin
            $display("Fail at %0t: misaligned store gave no error", $time);
            errors++;
        end
        lsu_access(1'b1, 32'h0000_030c, SIZE_D, 1'b0, '1, 0, got, err);
        assert (err) else begin
            $display("Fail at %0t: misaligned double store gave no error", $time);
            errors++;
        end
        check_load(32'h0000_0300, SIZE_D, 1'b0);
        check_load(32'h0000_0308, SIZE_D, 1'b0);
        // aligned load held under back-pressure
        lsu_access(1'b0, 32'h0000_0310, SIZE_W, 1'b0, '0, 6, got, err);
        assert (got == expect_load(32'h0000_0310, SIZE_W, 1'b0) && !err) else begin
            $display("Fail at %0t: held load got %h err %0b", $time, got, err);
            errors++;
        end
    endtask

    initial begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_pc        = '0;
        fetch_rsp_ready = 1'b0;
        jmp_flush       = 1'b0;
        lsu_req_valid   = 1'b0;
        lsu_addr        = '0;
        lsu_we          = 1'b0;
        lsu_wdata       = '0;
        lsu_size        = SIZE_B;
        lsu_unsigned    = 1'b0;
        lsu_rsp_ready   = 1'b0;
        errors          = 0;
        timeouts        = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = word_pattern(i);
        end
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        next_cycle();

        test_fetch_halves();
        test_load_sizes();
        test_store_merge();
        test_concurrent();
        test_flush();
        test_misaligned();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/core_mem_pkg.sv
src/inst_fetch.sv
src/load_store.sv
src/mem_arbiter.sv
src/core_mem_top.sv
tb/mem_model.sv
tb/tb_core_mem.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_core_mem -o sim_core_mem

./obj_dir/sim_core_mem | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
